//--- verilog/vwin_macros.svh
`ifndef VWIN_MACROS_SVH
`define VWIN_MACROS_SVH

// ************************************************************************
// Geometry of the vertical window engine
// ************************************************************************

// Pixels per image line, also the length of every row delay
`define VWIN_LINE_W 17

// Vertically aligned taps, tap 0 is the newest row
`define VWIN_TAPS 13

// Window radii, each sum covers taps 0 to 2*radius
`define VWIN_R_SMALL 2
`define VWIN_R_MID   4
`define VWIN_R_LARGE 6

`endif

//--- verilog/vwin_pkg.sv
`default_nettype none

`include "vwin_macros.svh"

package vwin_pkg;

  // ************************************************************************
  // Data types shared by the window engine
  // ************************************************************************

  // One raster pixel
  typedef logic [7:0] pixel_t;

  // Box sum, wide enough for 13 full-scale pixels (3315)
  typedef logic [11:0] sum_t;

  // One column of vertically aligned pixels
  typedef pixel_t tap_vec_t [`VWIN_TAPS];  // Index 0 is the newest row

endpackage

`default_nettype wire

//--- verilog/row_delay.sv
`timescale 1ns/1ns
`default_nettype none

// Fixed-length shift chain, one element in and one out per clock
module row_delay #(
  parameter type elem_t = logic,
  parameter int  LENGTH = 17
) (
  input  logic  clk,
  input  logic  rst_n,
  input  elem_t data_i,
  output elem_t data_o
);

  elem_t stage [LENGTH];  // Oldest element sits at LENGTH-1

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < LENGTH; i++) begin
        stage[i] <= '0;
      end
    end else begin
      stage[0] <= data_i;
      for (int i = 1; i < LENGTH; i++) begin
        stage[i] <= stage[i-1];  // Advance the whole row
      end
    end
  end

  // Sample taken LENGTH edges ago
  assign data_o = stage[LENGTH-1];

endmodule

`default_nettype wire

//--- verilog/row_buffer_bank.sv
`timescale 1ns/1ns
`default_nettype none

`include "vwin_macros.svh"

module row_buffer_bank (
  input  logic                   clk,
  input  logic                   rst_n,
  input  vwin_pkg::pixel_t       pixel_i,
  input  logic                   row_valid_i,
  output vwin_pkg::tap_vec_t     taps_o,
  output logic [`VWIN_TAPS-1:0]  tap_valid_o
);

  import vwin_pkg::*;

  // ************************************************************************
  // Valid extension
  // ************************************************************************

  logic [9:0] ext_cnt;       // Cycles since row_valid_i dropped
  logic       ext_valid;     // Keeps stage 0 alive while rows drain
  logic       stage0_valid;

  // Hold the level for one line plus one cycle after the frame ends
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ext_cnt   <= '0;
      ext_valid <= 1'b0;
    end else if (row_valid_i) begin
      ext_cnt   <= '0;  // Restart on every active cycle
      ext_valid <= 1'b1;
    end else if (ext_valid && (ext_cnt < 10'(`VWIN_LINE_W))) begin
      ext_cnt   <= ext_cnt + 10'd1;
      ext_valid <= 1'b1;
    end else begin
      ext_cnt   <= '0;
      ext_valid <= 1'b0;
    end
  end

  assign stage0_valid = row_valid_i | ext_valid;

  // ************************************************************************
  // Row delay chain
  // ************************************************************************

  // Tap 0 is the live input
  assign taps_o[0]      = pixel_i;
  assign tap_valid_o[0] = stage0_valid;

  // Each row feeds the next, tap k lags tap 0 by k lines
  generate
    for (genvar k = 1; k < `VWIN_TAPS; k++) begin : g_row
      row_delay #(
        .elem_t (pixel_t),
        .LENGTH (`VWIN_LINE_W)
      ) u_pix_delay (
        .clk    (clk),
        .rst_n  (rst_n),
        .data_i (taps_o[k-1]),
        .data_o (taps_o[k])
      );

      // Valid level travels beside its pixels
      row_delay #(
        .elem_t (logic),
        .LENGTH (`VWIN_LINE_W)
      ) u_valid_delay (
        .clk    (clk),
        .rst_n  (rst_n),
        .data_i (tap_valid_o[k-1]),
        .data_o (tap_valid_o[k])
      );
    end
  endgenerate

endmodule

`default_nettype wire

//--- verilog/window_sum.sv
`timescale 1ns/1ns
`default_nettype none

`include "vwin_macros.svh"

module window_sum (
  input  logic                   clk,
  input  logic                   rst_n,
  input  vwin_pkg::tap_vec_t     taps_i,
  input  logic [`VWIN_TAPS-1:0]  tap_valid_i,
  output vwin_pkg::sum_t         sum_small_o,
  output vwin_pkg::sum_t         sum_mid_o,
  output vwin_pkg::sum_t         sum_large_o,
  output logic                   valid_small_o,
  output logic                   valid_mid_o,
  output logic                   valid_large_o
);

  import vwin_pkg::*;

  // Deepest tap of each window
  localparam int TAP_SMALL = 2 * `VWIN_R_SMALL;
  localparam int TAP_MID   = 2 * `VWIN_R_MID;
  localparam int TAP_LARGE = 2 * `VWIN_R_LARGE;

  // ************************************************************************
  // Partial-sum chain
  // ************************************************************************

  // psum[k] holds taps 0..k, so every window is one entry of the chain
  sum_t psum [`VWIN_TAPS];

  always_comb begin
    psum[0] = sum_t'(taps_i[0]);
    for (int k = 1; k < `VWIN_TAPS; k++) begin
      psum[k] = psum[k-1] + sum_t'(taps_i[k]);
    end
  end

  // ************************************************************************
  // Sum register
  // ************************************************************************

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sum_small_o   <= '0;
      sum_mid_o     <= '0;
      sum_large_o   <= '0;
      valid_small_o <= 1'b0;
      valid_mid_o   <= 1'b0;
      valid_large_o <= 1'b0;
    end else begin
      sum_small_o   <= psum[TAP_SMALL];  // Radius 2
      sum_mid_o     <= psum[TAP_MID];    // Radius 4
      sum_large_o   <= psum[TAP_LARGE];  // Radius 6

      // A window is complete once its deepest row holds valid data
      valid_small_o <= tap_valid_i[TAP_SMALL];
      valid_mid_o   <= tap_valid_i[TAP_MID];
      valid_large_o <= tap_valid_i[TAP_LARGE];
    end
  end

endmodule

`default_nettype wire

//--- verilog/sum_output_stage.sv
`timescale 1ns/1ns
`default_nettype none

module sum_output_stage (
  input  logic            clk,
  input  logic            rst_n,
  input  vwin_pkg::sum_t  sum_small_i,
  input  vwin_pkg::sum_t  sum_mid_i,
  input  vwin_pkg::sum_t  sum_large_i,
  input  logic            valid_small_i,
  input  logic            valid_mid_i,
  input  logic            valid_large_i,
  output vwin_pkg::sum_t  sum_r2_o,
  output vwin_pkg::sum_t  sum_r4_o,
  output vwin_pkg::sum_t  sum_r6_o,
  output logic            valid_r2_o,
  output logic            valid_r4_o,
  output logic            valid_r6_o
);

  // Incomplete windows leave the engine as zero
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sum_r2_o   <= '0;
      sum_r4_o   <= '0;
      sum_r6_o   <= '0;
      valid_r2_o <= 1'b0;
      valid_r4_o <= 1'b0;
      valid_r6_o <= 1'b0;
    end else begin
      sum_r2_o   <= valid_small_i ? sum_small_i : '0;
      sum_r4_o   <= valid_mid_i   ? sum_mid_i   : '0;
      sum_r6_o   <= valid_large_i ? sum_large_i : '0;
      valid_r2_o <= valid_small_i;
      valid_r4_o <= valid_mid_i;
      valid_r6_o <= valid_large_i;
    end
  end

endmodule

`default_nettype wire

//--- verilog/vwin_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "vwin_macros.svh"

module vwin_top (
  input  logic              clk,
  input  logic              rst_n,
  input  vwin_pkg::pixel_t  pixel_i,
  input  logic              row_valid_i,
  output vwin_pkg::sum_t    sum_r2_o,
  output vwin_pkg::sum_t    sum_r4_o,
  output vwin_pkg::sum_t    sum_r6_o,
  output logic              valid_r2_o,
  output logic              valid_r4_o,
  output logic              valid_r6_o
);

  import vwin_pkg::*;

  tap_vec_t               taps;
  logic [`VWIN_TAPS-1:0]  tap_valid;
  sum_t                   sum_small;
  sum_t                   sum_mid;
  sum_t                   sum_large;
  logic                   valid_small;
  logic                   valid_mid;
  logic                   valid_large;

  // Thirteen aligned pixels of one column
  row_buffer_bank u_bank (
    .clk         (clk),
    .rst_n       (rst_n),
    .pixel_i     (pixel_i),
    .row_valid_i (row_valid_i),
    .taps_o      (taps),
    .tap_valid_o (tap_valid)
  );

  window_sum u_sum (
    .clk           (clk),
    .rst_n         (rst_n),
    .taps_i        (taps),
    .tap_valid_i   (tap_valid),
    .sum_small_o   (sum_small),
    .sum_mid_o     (sum_mid),
    .sum_large_o   (sum_large),
    .valid_small_o (valid_small),
    .valid_mid_o   (valid_mid),
    .valid_large_o (valid_large)
  );

  sum_output_stage u_out (
    .clk           (clk),
    .rst_n         (rst_n),
    .sum_small_i   (sum_small),
    .sum_mid_i     (sum_mid),
    .sum_large_i   (sum_large),
    .valid_small_i (valid_small),
    .valid_mid_i   (valid_mid),
    .valid_large_i (valid_large),
    .sum_r2_o      (sum_r2_o),
    .sum_r4_o      (sum_r4_o),
    .sum_r6_o      (sum_r6_o),
    .valid_r2_o    (valid_r2_o),
    .valid_r4_o    (valid_r4_o),
    .valid_r6_o    (valid_r6_o)
  );

endmodule

`default_nettype wire

//--- verification/vwin_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "vwin_macros.svh"

module vwin_tb;

  import vwin_pkg::*;

  localparam int W            = `VWIN_LINE_W;
  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 10;

  // Stimulus layout in whole lines
  localparam int IDLE_LINES   = 3;
  localparam int FRAME1_LINES = 20;
  localparam int GAP_LINES    = 2;
  localparam int FRAME2_LINES = 14;
  localparam int DRAIN_LINES  = 16;

  // Short drop of row_valid_i inside frame 1
  localparam int DROP_LINE  = 9;
  localparam int DROP_START = 6;
  localparam int DROP_LEN   = 5;

  localparam int TOTAL_CYCLES =
    W * (IDLE_LINES + FRAME1_LINES + GAP_LINES + FRAME2_LINES + DRAIN_LINES);
  localparam int HIST_LEN        = TOTAL_CYCLES + 4;
  localparam int WATCHDOG_CYCLES = TOTAL_CYCLES + RESET_CYCLES + 20 * W;

  localparam int RADIUS [3] = '{`VWIN_R_SMALL, `VWIN_R_MID, `VWIN_R_LARGE};

  logic   clk = 1'b0;
  logic   rst_n;
  pixel_t pixel_i;
  logic   row_valid_i;
  sum_t   sum_r2_o;
  sum_t   sum_r4_o;
  sum_t   sum_r6_o;
  logic   valid_r2_o;
  logic   valid_r4_o;
  logic   valid_r6_o;

  integer seed = 32'hed61_79dc;

  // Input history by edge number, edge 0 is the first edge out of reset
  logic [7:0] pix_hist [HIST_LEN];
  bit         s0v_hist [HIST_LEN];
  int         rec_edge      = 0;
  int         cmp_edge      = 0;
  bit         ext_model     = 1'b0;  // Extend level as the rule defines it
  int         ext_cnt_model = 0;
  int         first_rv_edge = -1;

  logic out_flag [3];
  sum_t out_sum [3];
  bit   exp_flag;
  int   exp_sum;
  int   rise_edge [3] = '{-1, -1, -1};
  int   max_hits [3]  = '{0, 0, 0};

  vwin_top DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .pixel_i     (pixel_i),
    .row_valid_i (row_valid_i),
    .sum_r2_o    (sum_r2_o),
    .sum_r4_o    (sum_r4_o),
    .sum_r6_o    (sum_r6_o),
    .valid_r2_o  (valid_r2_o),
    .valid_r4_o  (valid_r4_o),
    .valid_r6_o  (valid_r6_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ************************************************************************
  // Reference model
  // ************************************************************************

  // Expected output presented at edge e for one window radius
  function automatic void reference_window(input int radius, input int e,
                                           output bit flag, output int total);
    int depth;
    int base;
    depth = 2 * radius;
    base  = e - 2;  // Two register stages behind the taps
    flag  = 1'b0;
    total = 0;
    if (base - depth * W >= 0) begin
      flag = s0v_hist[base - depth * W];
    end
    if (flag) begin
      for (int k = 0; k <= depth; k++) begin
        total += int'(pix_hist[base - k * W]);
      end
    end
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR @ %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      $display("Simulation failed");
      $fatal(1, "Output mismatch");
    end
  endtask

  task automatic drive_cycle(input logic valid, input pixel_t pix);
    row_valid_i = valid;
    pixel_i     = pix;
    @(negedge clk);
  endtask

  // Record sampled inputs and track the stage-0 valid level
  always @(posedge clk) begin
    if (rst_n) begin
      pix_hist[rec_edge] = pixel_i;
      s0v_hist[rec_edge] = row_valid_i | ext_model;
      if (row_valid_i) begin
        ext_cnt_model = 0;  // Any active cycle restarts the extension
        ext_model     = 1'b1;
      end else if (ext_model && ext_cnt_model < W) begin
        ext_cnt_model++;
      end else begin
        ext_cnt_model = 0;
        ext_model     = 1'b0;
      end
      if (row_valid_i && first_rv_edge < 0) begin
        first_rv_edge = rec_edge;
      end
      rec_edge++;
    end
  end

  // ************************************************************************
  // Output comparison
  // ************************************************************************

  always @(posedge clk) begin
    if (rst_n) begin
      out_flag[0] = valid_r2_o;
      out_flag[1] = valid_r4_o;
      out_flag[2] = valid_r6_o;
      out_sum[0]  = sum_r2_o;
      out_sum[1]  = sum_r4_o;
      out_sum[2]  = sum_r6_o;
      for (int i = 0; i < 3; i++) begin
        reference_window(RADIUS[i], cmp_edge, exp_flag, exp_sum);
        check_value($sformatf("valid flag r%0d", RADIUS[i]),
                    32'(out_flag[i]), 32'(exp_flag));
        check_value($sformatf("sum r%0d", RADIUS[i]),
                    32'(out_sum[i]), 32'(exp_sum));
        // First rise lags the first active row by the window depth
        if (out_flag[i] && rise_edge[i] < 0) begin
          rise_edge[i] = cmp_edge;
          check_value($sformatf("first rise delay r%0d", RADIUS[i]),
                      cmp_edge - first_rv_edge, 2 + 2 * RADIUS[i] * W);
        end
        if (out_flag[i] && int'(out_sum[i]) == (2 * RADIUS[i] + 1) * 255) begin
          max_hits[i]++;
        end
      end
      cmp_edge++;
    end
  end

  // ************************************************************************
  // Stimulus
  // ************************************************************************

  initial begin
    rst_n       = 1'b0;
    pixel_i     = '0;
    row_valid_i = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;

    repeat (IDLE_LINES * W) begin
      drive_cycle(1'b0, pixel_t'($random(seed)));
    end

    // Frame 1, random pixels with a short valid drop
    for (int line = 0; line < FRAME1_LINES; line++) begin
      for (int x = 0; x < W; x++) begin
        drive_cycle(!(line == DROP_LINE && x >= DROP_START &&
                      x < DROP_START + DROP_LEN),
                    pixel_t'($random(seed)));
      end
    end

    repeat (GAP_LINES * W) begin
      drive_cycle(1'b0, pixel_t'($random(seed)));
    end

    // Frame 2 at full scale
    repeat (FRAME2_LINES * W) begin
      drive_cycle(1'b1, 8'hff);
    end

    // Let every row drain out of the bank
    repeat (DRAIN_LINES * W) begin
      drive_cycle(1'b0, 8'h00);
    end

    for (int i = 0; i < 3; i++) begin
      check_value($sformatf("flag r%0d ever rose", RADIUS[i]),
                  (rise_edge[i] >= 0) ? 1 : 0, 1);
      check_value($sformatf("full-scale windows seen r%0d", RADIUS[i]),
                  (max_hits[i] > 0) ? 1 : 0, 1);
    end

    $display("Simulation completed successfully");
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the run did not end within %0d clock cycles", WATCHDOG_CYCLES);
    $display("Simulation failed");
    $fatal(1, "Watchdog expired");
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+verilog
verilog/vwin_pkg.sv
verilog/row_delay.sv
verilog/row_buffer_bank.sv
verilog/window_sum.sv
verilog/sum_output_stage.sv
verilog/vwin_top.sv
verification/vwin_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the vertical window engine testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
  --timescale 1ns/1ns \
  -f verilog.f \
  --top-module vwin_tb \
  --Mdir obj_dir \
  -o vwin_sim

# A $fatal in the testbench gives a non-zero exit status
./obj_dir/vwin_sim
